/* flist.f */
src/motor_pkg.sv
src/sine_table.sv
src/sine_arbiter.sv
src/clarke_transform.sv
src/park_transform.sv
src/motor_frame_top.sv
tests/motor_frame_props.sv
tests/tb_motor_frame.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_motor_frame
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
ERR_LIMIT ?= 1000
PASS_TEXT ?= TESTBENCH PASSED
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) > $(LOG) 2>&1; true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_motor_frame.sv */
module tb_motor_frame;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CHANNEL_WIDTH = 2;
    localparam int PERIOD        = 8;
    localparam int N_ITEMS       = 68;  // both paths together
    localparam int TIMEOUT       = (N_ITEMS * 40 + 100) * PERIOD;

    // quadrant boundaries then one angle inside each quadrant
    localparam motor_pkg::angle_t ANGLES [8] = '{9'd0, 9'd128, 9'd256, 9'd384,
                                                 9'd45, 9'd170, 9'd300, 9'd470};

    logic                       clk = 1'b0;
    logic                       reset = 1'b1;
    motor_pkg::vector_t         cur_vec = '0;
    motor_pkg::angle_t          cur_theta = '0;
    logic [CHANNEL_WIDTH-1:0]   cur_channel = '0;
    logic                       cur_valid = 1'b0;
    logic                       cur_ready;
    motor_pkg::vector_t         volt_vec = '0;
    motor_pkg::angle_t          volt_theta = '0;
    logic [CHANNEL_WIDTH-1:0]   volt_channel = '0;
    logic                       volt_valid = 1'b0;
    logic                       volt_ready;
    motor_pkg::vector_t         dq_vec;
    logic [CHANNEL_WIDTH-1:0]   dq_channel;
    logic                       dq_valid;
    logic                       dq_ready = 1'b1;
    motor_pkg::vector_t         ab_vec;
    logic [CHANNEL_WIDTH-1:0]   ab_channel;
    logic                       ab_valid;
    logic                       ab_ready = 1'b1;

    integer seed = 32'h033d_5a5d;
    logic   wiggle = 1'b0;  // random back-pressure on both outputs
    int     cur_sent = 0;
    int     volt_sent = 0;
    int     dq_seen = 0;
    int     ab_seen = 0;

    motor_frame_top #(.CHANNEL_WIDTH(CHANNEL_WIDTH)) dut0 (.*);

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        #1;
        dq_ready <= wiggle ? (($random(seed) & 3) != 0) : 1'b1;
        ab_ready <= wiggle ? (($random(seed) & 3) != 0) : 1'b1;
    end

    // count transfers that the next rising edge completes
    always @(negedge clk) begin
        if (dq_valid && dq_ready) begin
            dq_seen++;
        end
        if (ab_valid && ab_ready) begin
            ab_seen++;
        end
    end

    function automatic motor_pkg::vector_t random_vec();
        motor_pkg::vector_t v;
        v.x = motor_pkg::sample_t'($random(seed) % 20000);
        v.y = motor_pkg::sample_t'($random(seed) % 20000);
        return v;
    endfunction

    function automatic motor_pkg::angle_t random_angle();
        return motor_pkg::angle_t'($random(seed));
    endfunction

    task automatic send_cur(input motor_pkg::vector_t vec, input motor_pkg::angle_t theta);
        cur_vec     = vec;
        cur_theta   = theta;
        cur_channel = CHANNEL_WIDTH'(cur_sent);
        cur_valid   = 1'b1;
        @(negedge clk);
        while (!cur_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        cur_valid = 1'b0;
        cur_sent++;
    endtask

    task automatic send_volt(input motor_pkg::vector_t vec, input motor_pkg::angle_t theta);
        volt_vec     = vec;
        volt_theta   = theta;
        volt_channel = CHANNEL_WIDTH'(volt_sent);
        volt_valid   = 1'b1;
        @(negedge clk);
        while (!volt_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        volt_valid = 1'b0;
        volt_sent++;
    endtask

    initial begin
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        for (int i = 0; i < 8; i++) begin
            send_cur(random_vec(), ANGLES[i]);
        end
        for (int i = 0; i < 8; i++) begin
            send_volt(random_vec(), ANGLES[i]);
        end
        // full scale at 64 clamps both rotations
        send_cur({16'h7fff, 16'h7fff}, 9'd64);
        send_cur({16'h8000, 16'h8000}, 9'd64);
        send_volt({16'h7fff, 16'h8000}, 9'd64);
        send_volt({16'h8000, 16'h8000}, 9'd64);
        fork
            repeat (12) send_cur(random_vec(), random_angle());
            repeat (12) send_volt(random_vec(), random_angle());
        join
        wiggle = 1'b1;
        fork
            repeat (12) send_cur(random_vec(), random_angle());
            repeat (12) send_volt(random_vec(), random_angle());
        join
        wiggle = 1'b0;
        wait (dq_seen == cur_sent && ab_seen == volt_sent);
        repeat (3) @(posedge clk);
        if (dut0.props0.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "a property check failed");
        end
    end

    always @(posedge clk) begin
        if (dut0.props0.fail_count != 0) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "a property check failed");
        end
    end

    initial begin
        #(TIMEOUT);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout, not every output arrived");
    end

endmodule

/* tests/motor_frame_props.sv */
module motor_frame_props #(
    parameter int CHANNEL_WIDTH = 2
) (
    input logic                     clk,
    input logic                     reset,
    input motor_pkg::vector_t       cur_vec,
    input motor_pkg::angle_t        cur_theta,
    input logic [CHANNEL_WIDTH-1:0] cur_channel,
    input logic                     cur_valid,
    input logic                     cur_ready,
    input motor_pkg::vector_t       volt_vec,
    input motor_pkg::angle_t        volt_theta,
    input logic [CHANNEL_WIDTH-1:0] volt_channel,
    input logic                     volt_valid,
    input logic                     volt_ready,
    input motor_pkg::vector_t       dq_vec,
    input logic [CHANNEL_WIDTH-1:0] dq_channel,
    input logic                     dq_valid,
    input logic                     dq_ready,
    input motor_pkg::vector_t       ab_vec,
    input logic [CHANNEL_WIDTH-1:0] ab_channel,
    input logic                     ab_valid,
    input logic                     ab_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_WAIT = 40;

    int unsigned                fail_count = 0;
    motor_pkg::vector_t         dq_exp [8];
    logic [CHANNEL_WIDTH-1:0]   dq_exp_ch [8];
    motor_pkg::vector_t         ab_exp [8];
    logic [CHANNEL_WIDTH-1:0]   ab_exp_ch [8];
    logic [2:0]                 dq_wr;
    logic [2:0]                 dq_rd;
    logic [2:0]                 ab_wr;
    logic [2:0]                 ab_rd;
    logic                       dq_take;
    logic                       ab_take;
    int                         dq_wait;
    int                         ab_wait;

    // signed sine of a 9-bit angle with a half wave per 256 steps
    function automatic longint sine_ref(input int angle);
        longint mag;
        mag = $rtoi(1024.0 * $sin(3.141592653589793 * real'(angle % 256) / 256.0) + 0.5);
        return ((angle % 512) >= 256) ? -mag : mag;
    endfunction

    function automatic longint clamp(input longint value);
        if (value > motor_pkg::DATA_MAX) begin
            return motor_pkg::DATA_MAX;
        end
        if (value < motor_pkg::DATA_MIN) begin
            return motor_pkg::DATA_MIN;
        end
        return value;
    endfunction

    function automatic motor_pkg::vector_t clarke_ref(input motor_pkg::vector_t v);
        longint a;
        longint b;
        motor_pkg::vector_t r;
        a   = v.x;
        b   = v.y;
        r.x = v.x;
        r.y = motor_pkg::sample_t'(clamp(((a + 2 * b) * 591) >>> 10));
        return r;
    endfunction

    function automatic motor_pkg::vector_t rotate_ref(input motor_pkg::vector_t v,
                                                      input int theta, input logic inverse);
        longint x;
        longint y;
        longint c;
        longint s;
        motor_pkg::vector_t r;
        x = v.x;
        y = v.y;
        c = sine_ref((theta + 128) % 512);  // cos is sin a quarter turn ahead
        s = inverse ? -sine_ref(theta) : sine_ref(theta);
        r.x = motor_pkg::sample_t'(clamp((x * c + y * s) >>> 10));
        r.y = motor_pkg::sample_t'(clamp((y * c - x * s) >>> 10));
        return r;
    endfunction

    // inputs and readies are stable at the falling edge
    always @(negedge clk or posedge reset) begin
        if (reset) begin
            dq_wr   <= '0;
            ab_wr   <= '0;
            dq_take <= 1'b0;
            ab_take <= 1'b0;
            dq_wait <= 0;
            ab_wait <= 0;
        end else begin
            if (cur_valid && cur_ready) begin
                dq_exp[dq_wr]    <= rotate_ref(clarke_ref(cur_vec), int'(cur_theta), 1'b0);
                dq_exp_ch[dq_wr] <= cur_channel;
                dq_wr            <= dq_wr + 3'd1;
            end
            if (volt_valid && volt_ready) begin
                ab_exp[ab_wr]    <= rotate_ref(volt_vec, int'(volt_theta), 1'b1);
                ab_exp_ch[ab_wr] <= volt_channel;
                ab_wr            <= ab_wr + 3'd1;
            end
            dq_take <= dq_valid && dq_ready;
            ab_take <= ab_valid && ab_ready;
            dq_wait <= (dq_valid || dq_wr == dq_rd) ? 0 : dq_wait + 1;  // pending with no output
            ab_wait <= (ab_valid || ab_wr == ab_rd) ? 0 : ab_wait + 1;
        end
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            dq_rd <= '0;
            ab_rd <= '0;
        end else begin
            if (dq_take) begin
                dq_rd <= dq_rd + 3'd1;
            end
            if (ab_take) begin
                ab_rd <= ab_rd + 3'd1;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        $past(reset) && $past(reset, 2) |-> !(dq_valid || ab_valid || cur_ready || volt_ready))
        else begin
            fail_count++;
            $error("valid or ready output high during reset");
        end

    a_ready_release: assert property (@(posedge clk) $fell(reset) |=> cur_ready && volt_ready)
        else begin
            fail_count++;
            $error("input readies did not rise one cycle after reset release");
        end

    a_dq_value: assert property (@(posedge clk) disable iff (reset)
        dq_valid |-> dq_wr != dq_rd && dq_vec == dq_exp[dq_rd] && dq_channel == dq_exp_ch[dq_rd])
        else begin
            fail_count++;
            $error("[ERROR] dq_vec 0x%h dq_channel 0x%h expected 0x%h 0x%h", $sampled(dq_vec),
                $sampled(dq_channel), dq_exp[$sampled(dq_rd)], dq_exp_ch[$sampled(dq_rd)]);
        end

    a_ab_value: assert property (@(posedge clk) disable iff (reset)
        ab_valid |-> ab_wr != ab_rd && ab_vec == ab_exp[ab_rd] && ab_channel == ab_exp_ch[ab_rd])
        else begin
            fail_count++;
            $error("[ERROR] ab_vec 0x%h ab_channel 0x%h expected 0x%h 0x%h", $sampled(ab_vec),
                $sampled(ab_channel), ab_exp[$sampled(ab_rd)], ab_exp_ch[$sampled(ab_rd)]);
        end

    a_dq_hold: assert property (@(posedge clk) disable iff (reset)
        dq_valid && !dq_ready |=> dq_valid && $stable(dq_vec) && $stable(dq_channel))
        else begin
            fail_count++;
            $error("dq output changed or dropped while dq_ready was low");
        end

    a_ab_hold: assert property (@(posedge clk) disable iff (reset)
        ab_valid && !ab_ready |=> ab_valid && $stable(ab_vec) && $stable(ab_channel))
        else begin
            fail_count++;
            $error("ab output changed or dropped while ab_ready was low");
        end

    a_dq_progress: assert property (@(posedge clk) disable iff (reset) dq_wait <= MAX_WAIT)
        else begin
            fail_count++;
            $error("current path item waited more than 40 cycles for its output");
        end

    a_ab_progress: assert property (@(posedge clk) disable iff (reset) ab_wait <= MAX_WAIT)
        else begin
            fail_count++;
            $error("voltage path item waited more than 40 cycles for its output");
        end

endmodule

bind motor_frame_top motor_frame_props #(.CHANNEL_WIDTH(CHANNEL_WIDTH)) props0 (.*);

/* src/motor_frame_top.sv */
module motor_frame_top #(
    parameter int CHANNEL_WIDTH = 2
) (
    input  logic                       clk,
    input  logic                       reset,

    input  motor_pkg::vector_t         cur_vec,
    input  motor_pkg::angle_t          cur_theta,
    input  logic [CHANNEL_WIDTH-1:0]   cur_channel,
    input  logic                       cur_valid,
    output logic                       cur_ready,

    input  motor_pkg::vector_t         volt_vec,
    input  motor_pkg::angle_t          volt_theta,
    input  logic [CHANNEL_WIDTH-1:0]   volt_channel,
    input  logic                       volt_valid,
    output logic                       volt_ready,

    output motor_pkg::vector_t         dq_vec,
    output logic [CHANNEL_WIDTH-1:0]   dq_channel,
    output logic                       dq_valid,
    input  logic                       dq_ready,

    output motor_pkg::vector_t         ab_vec,
    output logic [CHANNEL_WIDTH-1:0]   ab_channel,
    output logic                       ab_valid,
    input  logic                       ab_ready
);

    motor_pkg::rotate_req_t            clarke_req;
    logic [CHANNEL_WIDTH-1:0]          clarke_channel;
    logic                              clarke_valid;
    logic                              clarke_ready;
    motor_pkg::rotate_req_t            volt_req;

    motor_pkg::table_req_t [1:0]       table_req;  // 0 forward, 1 inverse
    logic [1:0]                        table_grant;
    motor_pkg::table_addr_t            rom_addr;
    motor_pkg::table_word_t            table_data;

    assign volt_req = '{inverse: 1'b1, theta: volt_theta, vec: volt_vec};

    clarke_transform #(
        .CHANNEL_WIDTH(CHANNEL_WIDTH)
    ) clarke (
        .clk        (clk),
        .reset      (reset),
        .in_vec     (cur_vec),
        .in_theta   (cur_theta),
        .in_channel (cur_channel),
        .in_valid   (cur_valid),
        .in_ready   (cur_ready),
        .out_req    (clarke_req),
        .out_channel(clarke_channel),
        .out_valid  (clarke_valid),
        .out_ready  (clarke_ready)
    );

    park_transform #(
        .CHANNEL_WIDTH(CHANNEL_WIDTH)
    ) park_fwd (
        .clk        (clk),
        .reset      (reset),
        .in_req     (clarke_req),
        .in_channel (clarke_channel),
        .in_valid   (clarke_valid),
        .in_ready   (clarke_ready),
        .table_req  (table_req[0]),
        .table_grant(table_grant[0]),
        .table_data (table_data),
        .out_vec    (dq_vec),
        .out_channel(dq_channel),
        .out_valid  (dq_valid),
        .out_ready  (dq_ready)
    );

    park_transform #(
        .CHANNEL_WIDTH(CHANNEL_WIDTH)
    ) park_inv (
        .clk        (clk),
        .reset      (reset),
        .in_req     (volt_req),
        .in_channel (volt_channel),
        .in_valid   (volt_valid),
        .in_ready   (volt_ready),
        .table_req  (table_req[1]),
        .table_grant(table_grant[1]),
        .table_data (table_data),
        .out_vec    (ab_vec),
        .out_channel(ab_channel),
        .out_valid  (ab_valid),
        .out_ready  (ab_ready)
    );

    sine_arbiter arbiter (
        .clk     (clk),
        .reset   (reset),
        .req     (table_req),
        .grant   (table_grant),
        .rom_addr(rom_addr)
    );

    sine_table rom (
        .clk (clk),
        .addr(rom_addr),
        .data(table_data)
    );

endmodule

/* src/park_transform.sv */
module park_transform #(
    parameter int CHANNEL_WIDTH = 2
) (
    input  logic                       clk,
    input  logic                       reset,
    input  motor_pkg::rotate_req_t     in_req,
    input  logic [CHANNEL_WIDTH-1:0]   in_channel,
    input  logic                       in_valid,
    output logic                       in_ready,
    output motor_pkg::table_req_t      table_req,
    input  logic                       table_grant,
    input  motor_pkg::table_word_t     table_data,
    output motor_pkg::vector_t         out_vec,
    output logic [CHANNEL_WIDTH-1:0]   out_channel,
    output logic                       out_valid,
    input  logic                       out_ready
);

    localparam int THETA_WIDTH = motor_pkg::THETA_WIDTH;
    localparam int COEF_WIDTH  = motor_pkg::TABLE_WIDTH + 1;
    localparam int PROD_WIDTH  = motor_pkg::DATA_WIDTH + COEF_WIDTH;
    localparam int ACC_WIDTH   = PROD_WIDTH + 1;
    localparam int QUARTER     = 2**(THETA_WIDTH - 2);

    typedef enum logic [2:0] {
        S_INIT,
        S_IDLE,
        S_SETUP,
        S_READ,
        S_WAIT,
        S_SAT,
        S_OUT
    } park_state_t;

    park_state_t                   state;
    motor_pkg::rotate_req_t        item;
    logic [CHANNEL_WIDTH-1:0]      channel;
    logic [1:0]                    rd_idx;
    logic [1:0]                    next_idx;
    motor_pkg::table_addr_t        next_addr;
    motor_pkg::angle_t             theta_cos;
    motor_pkg::table_addr_t        sin_addr;
    motor_pkg::table_addr_t        cos_addr;
    logic                          neg_cos;
    logic                          neg_sin;
    logic                          coef_neg;

    // pipeline tags follow each granted read
    logic                          data_pend;
    logic [1:0]                    data_idx;
    logic                          coef_pend;
    logic [1:0]                    coef_idx;
    logic                          prod_pend;
    logic [1:0]                    prod_idx;

    logic signed [COEF_WIDTH-1:0]  mag;
    logic signed [COEF_WIDTH-1:0]  coef;
    motor_pkg::sample_t            mult_a;
    logic signed [PROD_WIDTH-1:0]  prod;
    logic signed [ACC_WIDTH-1:0]   sum;
    motor_pkg::sample_t            sum_sat;

    assign theta_cos = item.theta + motor_pkg::angle_t'(QUARTER);
    assign sin_addr  = item.theta[THETA_WIDTH-2:0];
    assign cos_addr  = theta_cos[THETA_WIDTH-2:0];

    // sign of each term comes from the quadrant
    // since the table holds magnitudes only
    assign neg_cos = item.theta[THETA_WIDTH-1] ^ item.theta[THETA_WIDTH-2];
    assign neg_sin = item.inverse ^ item.theta[THETA_WIDTH-1];

    // read order cos, sin, sin, cos
    assign next_idx  = rd_idx + 2'd1;
    assign next_addr = (next_idx == 2'd1 || next_idx == 2'd2) ? sin_addr : cos_addr;

    always_comb begin
        case (data_idx)
            2'd0:    coef_neg = neg_cos;   // x * cos
            2'd1:    coef_neg = neg_sin;   // y * sin
            2'd2:    coef_neg = !neg_sin;  // -x * sin
            default: coef_neg = neg_cos;   // y * cos
        endcase
    end

    assign mag     = signed'({1'b0, table_data});
    assign sum_sat = motor_pkg::saturate(32'(sum >>> motor_pkg::TABLE_SCALE));

    assign in_ready    = (state == S_IDLE);
    assign out_valid   = (state == S_OUT);
    assign out_channel = channel;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_INIT;
            rd_idx    <= 2'd0;
            table_req <= '0;
            data_pend <= 1'b0;
            data_idx  <= 2'd0;
            coef_pend <= 1'b0;
            coef_idx  <= 2'd0;
            prod_pend <= 1'b0;
            prod_idx  <= 2'd0;
        end else begin
            case (state)
                S_INIT: state <= S_IDLE;
                S_IDLE: begin
                    if (in_valid) begin
                        state <= S_SETUP;
                    end
                end
                S_SETUP: begin
                    table_req.req  <= 1'b1;
                    table_req.addr <= cos_addr;
                    rd_idx         <= 2'd0;
                    state          <= S_READ;
                end
                S_READ: begin
                    if (table_grant) begin  // hold until granted
                        rd_idx <= next_idx;
                        if (rd_idx == 2'd3) begin
                            table_req.req <= 1'b0;
                            state         <= S_WAIT;
                        end else begin
                            table_req.addr <= next_addr;
                        end
                    end
                end
                S_WAIT: begin
                    if (prod_pend && prod_idx == 2'd3) begin
                        state <= S_SAT;
                    end
                end
                S_SAT: state <= S_OUT;
                S_OUT: begin
                    if (out_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase

            data_pend <= table_grant;
            data_idx  <= rd_idx;
            coef_pend <= data_pend;
            coef_idx  <= data_idx;
            prod_pend <= coef_pend;
            prod_idx  <= coef_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            item    <= in_req;
            channel <= in_channel;
        end
        if (data_pend) begin
            mult_a <= data_idx[0] ? item.vec.y : item.vec.x;
            coef   <= coef_neg ? -mag : mag;
        end
        if (coef_pend) begin
            prod <= PROD_WIDTH'(mult_a) * PROD_WIDTH'(coef);
        end
        if (prod_pend) begin
            case (prod_idx)
                2'd0: sum <= ACC_WIDTH'(prod);
                2'd2: begin
                    out_vec.x <= sum_sat;  // sum still holds x'
                    sum       <= ACC_WIDTH'(prod);
                end
                default: sum <= sum + ACC_WIDTH'(prod);
            endcase
        end
        if (state == S_SAT) begin
            out_vec.y <= sum_sat;
        end
    end

endmodule

/* src/clarke_transform.sv */
module clarke_transform #(
    parameter int CHANNEL_WIDTH = 2
) (
    input  logic                       clk,
    input  logic                       reset,
    input  motor_pkg::vector_t         in_vec,
    input  motor_pkg::angle_t          in_theta,
    input  logic [CHANNEL_WIDTH-1:0]   in_channel,
    input  logic                       in_valid,
    output logic                       in_ready,
    output motor_pkg::rotate_req_t     out_req,
    output logic [CHANNEL_WIDTH-1:0]   out_channel,
    output logic                       out_valid,
    input  logic                       out_ready
);

    localparam int SUM_WIDTH  = motor_pkg::DATA_WIDTH + 2;
    localparam int PROD_WIDTH = SUM_WIDTH + 11;

    localparam logic signed [10:0] BETA_GAIN = 11'sd591;  // 1/sqrt(3) at scale 10

    logic                          alive;
    logic signed [SUM_WIDTH-1:0]   a_plus_2b;
    logic signed [PROD_WIDTH-1:0]  beta_prod;
    motor_pkg::sample_t            beta;

    assign a_plus_2b = SUM_WIDTH'(in_vec.x) + (SUM_WIDTH'(in_vec.y) <<< 1);
    assign beta_prod = PROD_WIDTH'(a_plus_2b) * PROD_WIDTH'(BETA_GAIN);
    assign beta      = motor_pkg::saturate(32'(beta_prod >>> motor_pkg::TABLE_SCALE));

    // one-deep stage that refills in the cycle it drains
    assign in_ready = alive && (!out_valid || out_ready);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alive     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            alive <= 1'b1;
            if (in_valid && in_ready) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_req.inverse <= 1'b0;  // forward rotation
            out_req.theta   <= in_theta;
            out_req.vec.x   <= in_vec.x;  // alpha is phase a
            out_req.vec.y   <= beta;
            out_channel     <= in_channel;
        end
    end

endmodule

/* src/sine_arbiter.sv */
module sine_arbiter (
    input  logic                              clk,
    input  logic                              reset,
    input  motor_pkg::table_req_t [1:0]       req,
    output logic [1:0]                        grant,
    output motor_pkg::table_addr_t            rom_addr
);

    logic last_winner;  // 1 when port 1 was served last

    // on a tie the port not served last wins
    always_comb begin
        grant = 2'b00;
        if (req[0].req && (!req[1].req || last_winner)) begin
            grant[0] = 1'b1;
        end else if (req[1].req) begin
            grant[1] = 1'b1;
        end
    end

    // rom data comes back on the shared bus a cycle later
    // and each requester claims it by its own grant
    assign rom_addr = grant[1] ? req[1].addr : req[0].addr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_winner <= 1'b1;  // port 0 first
        end else if (grant != 2'b00) begin
            last_winner <= grant[1];
        end
    end

endmodule

/* src/sine_table.sv */
module sine_table (
    input  logic                   clk,
    input  motor_pkg::table_addr_t addr,
    output motor_pkg::table_word_t data
);

    localparam int DEPTH = 2**$bits(motor_pkg::table_addr_t);
    localparam int TERMS = 10;
    localparam real PI   = 3.14159265358979;

    // round(2^scale * sin(k*pi/DEPTH)) by power series
    function automatic motor_pkg::table_word_t sine_entry(input int k);
        real x;
        real term;
        real acc;
        int  folded;
        int  n;
        folded = (k <= DEPTH / 2) ? k : DEPTH - k;  // symmetric about pi/2
        x      = PI * real'(folded) / real'(DEPTH);
        term   = x;
        acc    = x;
        for (n = 1; n < TERMS; n++) begin
            term = -term * x * x / real'((2 * n) * (2 * n + 1));
            acc  = acc + term;
        end
        return motor_pkg::table_word_t'($rtoi(acc * real'(2**motor_pkg::TABLE_SCALE) + 0.5));
    endfunction

    motor_pkg::table_word_t rom [DEPTH];

    initial begin
        for (int k = 0; k < DEPTH; k++) begin
            rom[k] = sine_entry(k);
        end
    end

    always_ff @(posedge clk) begin
        data <= rom[addr];
    end

endmodule

/* src/motor_pkg.sv */
package motor_pkg;

    localparam int DATA_WIDTH  = 16;
    localparam int THETA_WIDTH = 9;   // 512 steps per turn
    localparam int TABLE_WIDTH = 12;
    localparam int TABLE_SCALE = 10;  // 1.0 is 1024

    localparam int DATA_MAX = 2**(DATA_WIDTH - 1) - 1;
    localparam int DATA_MIN = -(2**(DATA_WIDTH - 1));

    typedef logic signed [DATA_WIDTH-1:0] sample_t;
    typedef logic [THETA_WIDTH-1:0]       angle_t;
    typedef logic [THETA_WIDTH-2:0]       table_addr_t;  // half wave
    typedef logic [TABLE_WIDTH-1:0]       table_word_t;

    // alpha/beta, d/q or phase a/b
    typedef struct packed {
        sample_t x;
        sample_t y;
    } vector_t;

    typedef struct packed {
        logic    inverse;
        angle_t  theta;
        vector_t vec;
    } rotate_req_t;

    typedef struct packed {
        logic        req;
        table_addr_t addr;
    } table_req_t;

    // clamp a widened result back into the sample range
    function automatic sample_t saturate(input logic signed [31:0] value);
        if (value > DATA_MAX) begin
            return sample_t'(DATA_MAX);
        end
        if (value < DATA_MIN) begin
            return sample_t'(DATA_MIN);
        end
        return value[DATA_WIDTH-1:0];
    endfunction

endpackage
